/* verif/fl_golden.txt */
# malloc dq_vld dq_adr bp_thr wr_vld wr_addr wr_data rd_vld rd_addr exp_ma_adr exp_ma_bp exp_rd
# All hex. exp_ma_adr is checked when malloc is 1; exp_rd arrives two cycles after rd_vld.
# Allocation in order after init, with writes
1 0 0 02 1 0 a000 0 0 0 0 0000
1 0 0 02 1 1 a001 0 0 1 0 0000
1 0 0 02 1 2 a002 0 0 2 0 0000
1 0 0 02 0 0 0000 0 0 3 0 0000
0 0 0 02 0 0 0000 1 0 0 0 a000
0 0 0 02 0 0 0000 0 0 0 0 0000
0 0 0 02 0 0 0000 1 1 0 0 a001
# Forwarding from the pending write
0 0 0 02 1 3 b003 0 0 0 0 0000
0 0 0 02 0 0 0000 1 3 0 0 b003
0 0 0 02 1 2 b002 0 0 0 0 0000
0 0 0 02 0 0 0000 1 2 0 0 b002
0 0 0 02 0 0 0000 0 0 0 0 0000
0 0 0 02 0 0 0000 1 3 0 0 b003
# Dequeue and last-in first-out reuse
0 1 1 02 0 0 0000 0 0 0 0 0000
0 1 3 02 0 0 0000 0 0 0 0 0000
1 0 0 02 0 0 0000 0 0 3 0 0000
1 0 0 02 0 0 0000 0 0 1 0 0000
1 1 2 02 0 0 0000 0 0 2 0 0000
1 0 0 02 0 0 0000 0 0 4 0 0000
# Back-pressure around the threshold
0 0 0 0b 0 0 0000 0 0 0 1 0000
1 0 0 0a 0 0 0000 0 0 5 0 0000
0 0 0 0a 0 0 0000 0 0 0 1 0000
0 1 5 0a 0 0 0000 0 0 0 1 0000
0 0 0 0a 0 0 0000 0 0 0 0 0000
1 0 0 0a 0 0 0000 0 0 5 0 0000
0 0 0 0a 0 0 0000 1 0 0 1 a000

/* free_list_mgr.f */
design/fl_pkg.sv
design/free_list.sv
design/write_buffer.sv
design/bank_arbiter.sv
design/data_ram.sv
design/read_pipe.sv
design/fl_top.sv
verif/tb_fl_top.sv

/* verif/tb_fl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fl_top;

  import fl_pkg::*;

  typedef struct packed {
    logic    malloc;
    logic    dq_vld;
    addr_t   dq_adr;
    cnt_t    bp_thr;
    wr_req_t wr;
    rd_req_t rd;
    addr_t   exp_ma_adr;
    logic    exp_ma_bp;
    data_t   exp_rd_data;
  } golden_t;

  logic    clk;
  logic    rst;
  logic    ready;
  logic    malloc;
  addr_t   ma_adr;
  logic    ma_bp;
  cnt_t    bp_thr;
  logic    dq_vld;
  addr_t   dq_adr;
  wr_req_t wr;
  rd_req_t rd;
  rd_rsp_t rd_rsp;

  golden_t vecs [$];
  int      errors = 0;
  int      checks = 0;
  int      cycle_limit = 0;
  logic    rd_exp_vld_d1 = 1'b0;  // Read issued one cycle back.
  logic    rd_exp_vld_d2 = 1'b0;
  data_t   rd_exp_data_d1 = '0;
  data_t   rd_exp_data_d2 = '0;

  fl_top UUT (
    .clk    (clk),
    .rst    (rst),
    .ready  (ready),
    .malloc (malloc),
    .ma_adr (ma_adr),
    .ma_bp  (ma_bp),
    .bp_thr (bp_thr),
    .dq_vld (dq_vld),
    .dq_adr (dq_adr),
    .wr     (wr),
    .rd     (rd),
    .rd_rsp (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==============================
  // Helpers
  // ==============================
  task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    checks++;
    if (actual !== expected) begin
      $display("Error at %0t: %s: got %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic drive_idle();
    malloc = 1'b0;
    dq_vld = 1'b0;
    dq_adr = '0;
    bp_thr = '0;
    wr     = '0;
    rd     = '0;
  endtask

  task automatic drive_vec(input golden_t v);
    malloc = v.malloc;
    dq_vld = v.dq_vld;
    dq_adr = v.dq_adr;
    bp_thr = v.bp_thr;
    wr     = v.wr;
    rd     = v.rd;
  endtask

  // Response due now was issued two lines back.
  task automatic track_read_rsp(input logic vld, input data_t data);
    check_val(rd_rsp.vld, rd_exp_vld_d2, "read response valid");
    if (rd_exp_vld_d2) begin
      check_val(rd_rsp.data, rd_exp_data_d2, "read data");
    end
    rd_exp_vld_d2  = rd_exp_vld_d1;
    rd_exp_data_d2 = rd_exp_data_d1;
    rd_exp_vld_d1  = vld;
    rd_exp_data_d1 = data;
  endtask

  task automatic load_golden();
    int      fd;
    int      n;
    string   line;
    int      c_malloc, c_dq_vld, c_dq_adr, c_thr, c_wr_vld, c_wr_addr;
    int      c_wr_data, c_rd_vld, c_rd_addr, c_ma_adr, c_ma_bp, c_rd_data;
    golden_t v;
    fd = $fopen("verif/fl_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file verif/fl_golden.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                      c_malloc, c_dq_vld, c_dq_adr, c_thr, c_wr_vld, c_wr_addr,
                      c_wr_data, c_rd_vld, c_rd_addr, c_ma_adr, c_ma_bp, c_rd_data);
          if (n == 12) begin
            v.malloc      = c_malloc[0];
            v.dq_vld      = c_dq_vld[0];
            v.dq_adr      = addr_t'(c_dq_adr);
            v.bp_thr      = cnt_t'(c_thr);
            v.wr.vld      = c_wr_vld[0];
            v.wr.addr     = addr_t'(c_wr_addr);
            v.wr.data     = data_t'(c_wr_data);
            v.rd.vld      = c_rd_vld[0];
            v.rd.addr     = addr_t'(c_rd_addr);
            v.exp_ma_adr  = addr_t'(c_ma_adr);
            v.exp_ma_bp   = c_ma_bp[0];
            v.exp_rd_data = data_t'(c_rd_data);
            vecs.push_back(v);
          end else if (n > 0) begin
            $display("Malformed line in the golden file: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ==============================
  // Timeout
  // ==============================
  initial begin
    int cycle_cnt;
    cycle_cnt = 0;
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Run did not finish within %0d cycles", cycle_limit);
    $display("tests failed");
    $finish;
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    int waited;
    rst = 1'b1;
    drive_idle();
    load_golden();
    cycle_limit = 3 * vecs.size() + NUM_ADDR + 20;
    repeat (3) @(posedge clk);
    #0.5;
    rst = 1'b0;
    waited = 0;
    while (!ready && waited < NUM_ADDR + 8) begin
      @(posedge clk);
      #0.5;
      waited++;
    end
    if (!ready) begin
      $display("ready never rose after reset");
      errors++;
    end else begin
      check_val(waited, NUM_ADDR, "cycles from reset release to ready");
      foreach (vecs[i]) begin
        drive_vec(vecs[i]);
        @(negedge clk);  // Outputs settled mid-cycle.
        if (vecs[i].malloc) begin
          check_val(ma_adr, vecs[i].exp_ma_adr, "malloc address");
        end
        check_val(ma_bp, vecs[i].exp_ma_bp, "back-pressure");
        track_read_rsp(vecs[i].rd.vld, vecs[i].exp_rd_data);
        @(posedge clk);
        #0.5;
      end
      drive_idle();
      repeat (READ_LAT) begin
        @(negedge clk);
        track_read_rsp(1'b0, '0);  // Drain outstanding reads.
        @(posedge clk);
        #0.5;
      end
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/fl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fl_top (
  input  wire logic            clk,
  input  wire logic            rst,
  output logic                 ready,
  input  wire logic            malloc,
  output fl_pkg::addr_t        ma_adr,
  output logic                 ma_bp,
  input  wire fl_pkg::cnt_t    bp_thr,
  input  wire logic            dq_vld,
  input  wire fl_pkg::addr_t   dq_adr,
  input  wire fl_pkg::wr_req_t wr,
  input  wire fl_pkg::rd_req_t rd,
  output fl_pkg::rd_rsp_t      rd_rsp
);

  import fl_pkg::*;

  wr_req_t  buf_req;
  ram_cmd_t ram_cmd;
  logic     drain;
  logic     fwd_hit;
  data_t    fwd_data;
  data_t    ram_dout;

  // ==============================
  // Address management
  // ==============================
  free_list u_free_list (
    .clk    (clk),
    .rst    (rst),
    .malloc (malloc),
    .dq_vld (dq_vld),
    .dq_adr (dq_adr),
    .bp_thr (bp_thr),
    .ready  (ready),
    .ma_adr (ma_adr),
    .ma_bp  (ma_bp)
  );

  // ==============================
  // Data path
  // ==============================
  write_buffer u_write_buffer (
    .clk      (clk),
    .rst      (rst),
    .wr       (wr),
    .rd       (rd),
    .drain    (drain),
    .buf_req  (buf_req),
    .fwd_hit  (fwd_hit),
    .fwd_data (fwd_data)
  );

  bank_arbiter u_bank_arbiter (
    .rd      (rd),
    .buf_req (buf_req),
    .ram_cmd (ram_cmd),
    .drain   (drain)
  );

  data_ram u_data_ram (
    .clk      (clk),
    .ram_cmd  (ram_cmd),
    .ram_dout (ram_dout)
  );

  read_pipe u_read_pipe (
    .clk      (clk),
    .rst      (rst),
    .rd       (rd),
    .fwd_hit  (fwd_hit),
    .fwd_data (fwd_data),
    .ram_dout (ram_dout),
    .rd_rsp   (rd_rsp)
  );

endmodule

`default_nettype wire

/* design/read_pipe.sv */
`timescale 1ns/100ps
`default_nettype none

module read_pipe (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire fl_pkg::rd_req_t rd,
  input  wire logic            fwd_hit,
  input  wire fl_pkg::data_t   fwd_data,
  input  wire fl_pkg::data_t   ram_dout,
  output fl_pkg::rd_rsp_t      rd_rsp
);

  import fl_pkg::*;

  logic  s1_vld;
  logic  s1_hit;
  data_t s1_data;
  logic  rsp_vld;
  data_t rsp_data;

  // ==============================
  // Valid pipeline
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld  <= 1'b0;
      rsp_vld <= 1'b0;
    end else begin
      s1_vld  <= rd.vld;
      rsp_vld <= s1_vld;
    end
  end

  // ==============================
  // Data pipeline
  // ==============================
  always_ff @(posedge clk) begin
    s1_hit   <= fwd_hit;
    s1_data  <= fwd_data;
    rsp_data <= s1_hit ? s1_data : ram_dout;  // RAM output lands here.
  end

  assign rd_rsp = '{vld: rsp_vld, data: rsp_data};

endmodule

`default_nettype wire

/* design/data_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module data_ram (
  input  wire logic             clk,
  input  wire fl_pkg::ram_cmd_t ram_cmd,
  output fl_pkg::data_t         ram_dout
);

  import fl_pkg::*;

  data_t mem [NUM_ADDR];

  always_ff @(posedge clk) begin
    if (ram_cmd.en) begin
      if (ram_cmd.we) begin
        mem[ram_cmd.addr] <= ram_cmd.data;
      end else begin
        ram_dout <= mem[ram_cmd.addr];  // Valid the next cycle.
      end
    end
  end

endmodule

`default_nettype wire

/* design/bank_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bank_arbiter (
  input  wire fl_pkg::rd_req_t rd,
  input  wire fl_pkg::wr_req_t buf_req,
  output fl_pkg::ram_cmd_t     ram_cmd,
  output logic                 drain
);

  // Reads always win the port.
  assign drain = buf_req.vld && !rd.vld;

  always_comb begin
    ram_cmd.en   = rd.vld || buf_req.vld;
    ram_cmd.we   = drain;
    ram_cmd.addr = rd.vld ? rd.addr : buf_req.addr;
    ram_cmd.data = buf_req.data;  // Ignored on reads.
  end

endmodule

`default_nettype wire

/* design/write_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module write_buffer (
  input  wire logic            clk,
  input  wire logic            rst,
  input  wire fl_pkg::wr_req_t wr,
  input  wire fl_pkg::rd_req_t rd,
  input  wire logic            drain,
  output fl_pkg::wr_req_t      buf_req,
  output logic                 fwd_hit,
  output fl_pkg::data_t        fwd_data
);

  import fl_pkg::*;

  logic  buf_vld;
  addr_t buf_addr;
  data_t buf_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_vld <= 1'b0;
    end else if (wr.vld) begin
      buf_vld <= 1'b1;
    end else if (drain) begin
      buf_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.vld) begin
      buf_addr <= wr.addr;
      buf_data <= wr.data;
    end
  end

  assign buf_req = '{vld: buf_vld, addr: buf_addr, data: buf_data};

  // Read sees the pending write before it reaches the RAM.
  assign fwd_hit  = buf_vld && rd.vld && (rd.addr == buf_addr);
  assign fwd_data = buf_data;

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    (wr.vld && buf_vld) |-> drain
  ) else $error("write arrived with an undrained entry held");

endmodule

`default_nettype wire

/* design/free_list.sv */
`timescale 1ns/100ps
`default_nettype none

module free_list (
  input  wire logic          clk,
  input  wire logic          rst,
  input  wire logic          malloc,
  input  wire logic          dq_vld,
  input  wire fl_pkg::addr_t dq_adr,
  input  wire fl_pkg::cnt_t  bp_thr,
  output logic               ready,
  output fl_pkg::addr_t      ma_adr,
  output logic               ma_bp
);

  import fl_pkg::*;

  addr_t link [NUM_ADDR];  // Next free address per entry.
  addr_t head;
  cnt_t  free_cnt;
  addr_t init_idx;
  logic  pop;
  logic  push;

  // A malloc paired with a dequeue takes the returned address directly.
  assign pop  = ready && malloc && !dq_vld;
  assign push = ready && dq_vld && !malloc;

  assign ma_adr = (malloc && dq_vld) ? dq_adr : head;
  assign ma_bp  = !ready || (free_cnt <= bp_thr);

  // ==============================
  // Init sequence
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      init_idx <= '0;
      ready    <= 1'b0;
    end else if (!ready) begin
      init_idx <= init_idx + 1'b1;
      if (init_idx == addr_t'(NUM_ADDR - 1)) begin
        ready <= 1'b1;  // Last link written.
      end
    end
  end

  // ==============================
  // Link array
  // ==============================
  always_ff @(posedge clk) begin
    if (!ready) begin
      link[init_idx] <= init_idx + 1'b1;  // Chain i to i+1.
    end else if (push) begin
      link[dq_adr] <= head;
    end
  end

  // ==============================
  // Head and count
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      head     <= '0;
      free_cnt <= cnt_t'(NUM_ADDR);
    end else if (pop) begin
      head     <= link[head];
      free_cnt <= free_cnt - 1'b1;
    end else if (push) begin
      head     <= dq_adr;  // Last in, first out.
      free_cnt <= free_cnt + 1'b1;
    end
  end

  a_no_malloc_under_bp: assert property (
    @(posedge clk) disable iff (rst)
    malloc |-> !ma_bp
  ) else $error("malloc issued while ma_bp is high");

  a_no_dequeue_when_full: assert property (
    @(posedge clk) disable iff (rst)
    (dq_vld && !malloc) |-> (free_cnt < cnt_t'(NUM_ADDR))
  ) else $error("dequeue issued with free list full");

endmodule

`default_nettype wire

/* design/fl_pkg.sv */
`default_nettype none

package fl_pkg;

  // ==============================
  // Sizes
  // ==============================
  localparam int NUM_ADDR = 16;
  localparam int ADDR_W   = 4;
  localparam int DATA_W   = 16;
  localparam int CNT_W    = 5;  // Holds 0 to NUM_ADDR.
  localparam int READ_LAT = 2;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // ==============================
  // Request and response words
  // ==============================
  typedef struct packed {
    logic  vld;
    addr_t addr;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    logic  vld;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  en;
    logic  we;
    addr_t addr;
    data_t data;
  } ram_cmd_t;

  typedef struct packed {
    logic  vld;
    data_t data;
  } rd_rsp_t;

endpackage

`default_nettype wire
